// ==== rtl/tag_pkg.sv ====
package tag_pkg;

    //////////////////////////////////////////////////
    // Sizes

    localparam int TAG_W     = 8;   // Tag width in bits
    localparam int TAG_DEPTH = 16;  // Slots in the tag array
    localparam int CNT_W     = 16;  // Counter and occupancy width

    localparam int APB_AW = 8;      // APB address width
    localparam int APB_DW = 32;     // APB data width

    //////////////////////////////////////////////////
    // Register byte offsets

    localparam logic [APB_AW-1:0] REG_CMD        = 8'h00;  // Write only command
    localparam logic [APB_AW-1:0] REG_STATUS     = 8'h04;
    localparam logic [APB_AW-1:0] REG_ALLOC_CNT  = 8'h08;
    localparam logic [APB_AW-1:0] REG_REJECT_CNT = 8'h0C;
    localparam logic [APB_AW-1:0] REG_MISS_CNT   = 8'h10;
    localparam logic [APB_AW-1:0] REG_OCCUPANCY  = 8'h14;

    // Field positions inside REG_CMD and REG_STATUS
    localparam int CMD_TAG_LSB  = 8;  // Tag sits in bits 15:8
    localparam int STS_EMPTY    = 0;
    localparam int STS_FULL     = 1;
    localparam int STS_LAST_HIT = 2;

    //////////////////////////////////////////////////
    // Command opcodes, bits 1:0 of REG_CMD

    typedef enum logic [1:0] {
        OP_NOP    = 2'd0,  // No action
        OP_ALLOC  = 2'd1,  // Store tag in lowest free slot
        OP_RETIRE = 2'd2,  // Drop one stored copy
        OP_LOOKUP = 2'd3   // Presence check only
    } tag_op_e;

endpackage : tag_pkg

// ==== rtl/apb_tag_if.sv ====
`timescale 1ns/10ps

module apb_tag_if (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    // APB slave side
    input  logic                           i_psel,
    input  logic                           i_penable,
    input  logic                           i_pwrite,
    input  logic [tag_pkg::APB_AW-1:0]     i_paddr,
    input  logic [tag_pkg::APB_DW-1:0]     i_pwdata,
    output logic [tag_pkg::APB_DW-1:0]     o_prdata,
    output logic                           o_pready,
    output logic                           o_pslverr,
    // Status coming back from the CAM and result stages
    input  logic                           i_empty,
    input  logic                           i_full,
    input  logic [tag_pkg::CNT_W-1:0]      i_occupancy,
    input  logic                           i_last_hit,
    input  logic [tag_pkg::CNT_W-1:0]      i_alloc_cnt,
    input  logic [tag_pkg::CNT_W-1:0]      i_reject_cnt,
    input  logic [tag_pkg::CNT_W-1:0]      i_miss_cnt,
    // Command towards the CAM
    output logic                           o_cmd_valid,
    output tag_pkg::tag_op_e               o_cmd_op,
    output logic [tag_pkg::TAG_W-1:0]      o_cmd_tag
);

    logic                           acc_phase;   // Second APB cycle
    logic                           addr_hit;    // Address is in the map
    logic                           bad_acc;     // Unmapped or illegal write
    logic                           cmd_wr;      // Legal write to REG_CMD
    tag_pkg::tag_op_e               wr_op;       // Opcode field of PWDATA
    logic [tag_pkg::APB_DW-1:0]     rd_mux;      // Read data before gating

    //////////////////////////////////////////////////
    // Access decode

    assign acc_phase = i_psel & i_penable;

    // Only REG_CMD accepts writes, everything else mapped is read only
    assign bad_acc = ~addr_hit | (i_pwrite & (i_paddr != tag_pkg::REG_CMD));

    assign cmd_wr = acc_phase & i_pwrite & ~bad_acc;

    assign wr_op = tag_pkg::tag_op_e'(i_pwdata[1:0]);

    assign o_pready  = 1'b1;                   // No wait states
    assign o_pslverr = acc_phase & bad_acc;    // Error only in access phase

    //////////////////////////////////////////////////
    // Command capture

    // Strobe lasts exactly one cycle after the access edge
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cmd_valid <= 1'b0;
        end else begin
            o_cmd_valid <= cmd_wr && (wr_op != tag_pkg::OP_NOP);  // NOP is dropped here
        end
    end

    // Opcode and tag only matter while the strobe is high
    always_ff @(posedge i_clk) begin
        if (cmd_wr) begin
            o_cmd_op  <= wr_op;
            o_cmd_tag <= i_pwdata[tag_pkg::CMD_TAG_LSB +: tag_pkg::TAG_W];
        end
    end

    //////////////////////////////////////////////////
    // Read mux

    always_comb begin
        addr_hit = 1'b1;
        rd_mux   = '0;
        case (i_paddr)
            tag_pkg::REG_CMD: begin
                // Reads back the last command written
                rd_mux[1:0] = o_cmd_op;
                rd_mux[tag_pkg::CMD_TAG_LSB +: tag_pkg::TAG_W] = o_cmd_tag;
            end
            tag_pkg::REG_STATUS: begin
                rd_mux[tag_pkg::STS_EMPTY]    = i_empty;
                rd_mux[tag_pkg::STS_FULL]     = i_full;
                rd_mux[tag_pkg::STS_LAST_HIT] = i_last_hit;
            end
            tag_pkg::REG_ALLOC_CNT: begin
                rd_mux[tag_pkg::CNT_W-1:0] = i_alloc_cnt;   // Zero extended
            end
            tag_pkg::REG_REJECT_CNT: begin
                rd_mux[tag_pkg::CNT_W-1:0] = i_reject_cnt;
            end
            tag_pkg::REG_MISS_CNT: begin
                rd_mux[tag_pkg::CNT_W-1:0] = i_miss_cnt;
            end
            tag_pkg::REG_OCCUPANCY: begin
                rd_mux[tag_pkg::CNT_W-1:0] = i_occupancy;
            end
            default: begin
                addr_hit = 1'b0;   // Unmapped, data stays zero
            end
        endcase
    end

    // Drive data only for a selected read
    assign o_prdata = (i_psel && !i_pwrite) ? rd_mux : '0;

endmodule : apb_tag_if

// ==== rtl/cam_tag.sv ====
`timescale 1ns/10ps

module cam_tag #(
    parameter int N     = tag_pkg::TAG_W,      // Tag width
    parameter int DEPTH = tag_pkg::TAG_DEPTH   // Number of tag slots
) (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_cmd_valid,
    input  tag_pkg::tag_op_e              i_cmd_op,
    input  logic [N-1:0]                  i_cmd_tag,
    output logic                          o_res_valid,
    output tag_pkg::tag_op_e              o_res_op,
    output logic                          o_res_ok,
    output logic                          o_empty,
    output logic                          o_full,
    output logic [tag_pkg::CNT_W-1:0]     o_occupancy
);

    logic [N-1:0]                tag_mem [DEPTH];  // Tag storage
    logic [DEPTH-1:0]            slot_vld;         // Slot holds a live tag
    logic [tag_pkg::CNT_W-1:0]   occ_cnt;          // Number of set valid bits

    logic                        free_found;
    logic [$clog2(DEPTH)-1:0]    free_idx;         // Lowest free slot
    logic                        match_found;
    logic [$clog2(DEPTH)-1:0]    match_idx;        // Highest matching slot

    logic                        do_alloc;
    logic                        do_retire;
    logic                        ok_nxt;

    //////////////////////////////////////////////////
    // Slot searches

    // Scan downwards so the lowest free index wins
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!slot_vld[i]) begin
                free_found = 1'b1;
                free_idx   = i[$clog2(DEPTH)-1:0];
            end
        end
    end

    // Scan upwards so the highest matching index wins
    always_comb begin
        match_found = 1'b0;
        match_idx   = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (slot_vld[i] && (tag_mem[i] == i_cmd_tag)) begin
                match_found = 1'b1;
                match_idx   = i[$clog2(DEPTH)-1:0];
            end
        end
    end

    //////////////////////////////////////////////////
    // Command decode

    assign do_alloc  = i_cmd_valid && (i_cmd_op == tag_pkg::OP_ALLOC) && free_found;
    assign do_retire = i_cmd_valid && (i_cmd_op == tag_pkg::OP_RETIRE) && match_found;

    always_comb begin
        case (i_cmd_op)
            tag_pkg::OP_ALLOC:  ok_nxt = free_found;    // Fails when full
            tag_pkg::OP_RETIRE: ok_nxt = match_found;   // Fails on a miss
            tag_pkg::OP_LOOKUP: ok_nxt = match_found;
            default:            ok_nxt = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // State update

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            slot_vld <= '0;
            occ_cnt  <= '0;
        end else if (do_alloc) begin
            slot_vld[free_idx] <= 1'b1;
            occ_cnt            <= occ_cnt + 1'b1;
        end else if (do_retire) begin
            slot_vld[match_idx] <= 1'b0;   // Tag data is left in place
            occ_cnt             <= occ_cnt - 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_alloc) tag_mem[free_idx] <= i_cmd_tag;
    end

    // Outcome trails the command by one cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_res_valid <= 1'b0;
            o_res_op    <= tag_pkg::OP_NOP;
            o_res_ok    <= 1'b0;
        end else begin
            o_res_valid <= i_cmd_valid;
            if (i_cmd_valid) begin
                o_res_op <= i_cmd_op;
                o_res_ok <= ok_nxt;
            end
        end
    end

    assign o_empty     = ~|slot_vld;
    assign o_full      =  &slot_vld;
    assign o_occupancy = occ_cnt;

endmodule : cam_tag

// ==== rtl/tag_result_stage.sv ====
`timescale 1ns/10ps

module tag_result_stage (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    // Outcome from the CAM
    input  logic                          i_res_valid,
    input  tag_pkg::tag_op_e              i_res_op,
    input  logic                          i_res_ok,
    // Host visible statistics
    output logic                          o_last_hit,
    output logic [tag_pkg::CNT_W-1:0]     o_alloc_cnt,
    output logic [tag_pkg::CNT_W-1:0]     o_reject_cnt,
    output logic [tag_pkg::CNT_W-1:0]     o_miss_cnt
);

    logic                          alloc_ev;    // Alloc stored
    logic                          reject_ev;   // Alloc refused, array full
    logic                          miss_ev;     // Retire found nothing
    logic                          lookup_ev;

    //////////////////////////////////////////////////
    // Saturating increment

    // Holds at all ones instead of wrapping
    function automatic logic [tag_pkg::CNT_W-1:0] sat_inc(
        input logic [tag_pkg::CNT_W-1:0] val
    );
        logic [tag_pkg::CNT_W-1:0] nxt;
        nxt = &val ? val : val + 1'b1;
        return nxt;
    endfunction

    //////////////////////////////////////////////////
    // Event decode

    always_comb begin
        alloc_ev  = 1'b0;
        reject_ev = 1'b0;
        miss_ev   = 1'b0;
        lookup_ev = 1'b0;
        if (i_res_valid) begin
            case (i_res_op)
                tag_pkg::OP_ALLOC: begin
                    alloc_ev  = i_res_ok;
                    reject_ev = ~i_res_ok;
                end
                tag_pkg::OP_RETIRE: begin
                    miss_ev = ~i_res_ok;   // Successful retire is not counted
                end
                tag_pkg::OP_LOOKUP: begin
                    lookup_ev = 1'b1;
                end
                default: begin
                    // NOP never reaches here, nothing to count
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Counters and sticky status

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_last_hit   <= 1'b0;
            o_alloc_cnt  <= '0;
            o_reject_cnt <= '0;
            o_miss_cnt   <= '0;
        end else begin
            if (lookup_ev) o_last_hit <= i_res_ok;   // Held until the next lookup
            if (alloc_ev)  o_alloc_cnt <= sat_inc(o_alloc_cnt);
            if (reject_ev) o_reject_cnt <= sat_inc(o_reject_cnt);
            if (miss_ev)   o_miss_cnt <= sat_inc(o_miss_cnt);
        end
    end

endmodule : tag_result_stage

// ==== rtl/tag_tracker_top.sv ====
`timescale 1ns/10ps

module tag_tracker_top (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    // APB slave
    input  logic                           i_psel,
    input  logic                           i_penable,
    input  logic                           i_pwrite,
    input  logic [tag_pkg::APB_AW-1:0]     i_paddr,
    input  logic [tag_pkg::APB_DW-1:0]     i_pwdata,
    output logic [tag_pkg::APB_DW-1:0]     o_prdata,
    output logic                           o_pready,
    output logic                           o_pslverr
);

    // Stage 1 to stage 2
    logic                          cmd_valid;
    tag_pkg::tag_op_e              cmd_op;
    logic [tag_pkg::TAG_W-1:0]     cmd_tag;

    // Stage 2 to stage 3
    logic                          res_valid;
    tag_pkg::tag_op_e              res_op;
    logic                          res_ok;

    // Status back to the register block
    logic                          empty;
    logic                          full;
    logic [tag_pkg::CNT_W-1:0]     occupancy;
    logic                          last_hit;
    logic [tag_pkg::CNT_W-1:0]     alloc_cnt;
    logic [tag_pkg::CNT_W-1:0]     reject_cnt;
    logic [tag_pkg::CNT_W-1:0]     miss_cnt;

    apb_tag_if u_apb_tag_if (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .i_empty      (empty),
        .i_full       (full),
        .i_occupancy  (occupancy),
        .i_last_hit   (last_hit),
        .i_alloc_cnt  (alloc_cnt),
        .i_reject_cnt (reject_cnt),
        .i_miss_cnt   (miss_cnt),
        .o_cmd_valid  (cmd_valid),
        .o_cmd_op     (cmd_op),
        .o_cmd_tag    (cmd_tag)
    );

    cam_tag u_cam_tag (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cmd_valid (cmd_valid),
        .i_cmd_op    (cmd_op),
        .i_cmd_tag   (cmd_tag),
        .o_res_valid (res_valid),
        .o_res_op    (res_op),
        .o_res_ok    (res_ok),
        .o_empty     (empty),
        .o_full      (full),
        .o_occupancy (occupancy)
    );

    tag_result_stage u_tag_result_stage (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_res_valid  (res_valid),
        .i_res_op     (res_op),
        .i_res_ok     (res_ok),
        .o_last_hit   (last_hit),
        .o_alloc_cnt  (alloc_cnt),
        .o_reject_cnt (reject_cnt),
        .o_miss_cnt   (miss_cnt)
    );

endmodule : tag_tracker_top

// ==== dv/tag_tracker_sva.sv ====
`timescale 1ns/10ps

module tag_tracker_sva #(
    parameter int DEPTH = tag_pkg::TAG_DEPTH   // Slots in the bound CAM
) (
    input logic                          i_clk,
    input logic                          i_rst_n,
    input logic                          i_cmd_valid,
    input logic                          i_res_valid,
    input logic                          i_empty,
    input logic                          i_full,
    input logic [tag_pkg::CNT_W-1:0]     i_occupancy
);

    //////////////////////////////////////////////////
    // CAM status and outcome rules

    // Array cannot be empty and full at once
    a_empty_full_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_empty && i_full))
        else $error("CAM flags empty and full in the same cycle");

    // One outcome per command, one cycle later
    a_res_follows_cmd: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_res_valid == $past(i_cmd_valid))
        else $error("CAM outcome strobe does not trail the command strobe");

    a_occ_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        int'(i_occupancy) <= DEPTH)   // Count tracks the valid bits
        else $error("CAM occupancy is above the number of slots");

    // No outcome while the pipe is held in reset
    a_res_idle_rst: assert property (@(posedge i_clk)
        !i_rst_n |-> !i_res_valid)
        else $error("CAM outcome strobe high during reset");

endmodule : tag_tracker_sva

// ==== dv/tag_tracker_tb.sv ====
`timescale 1ns/10ps

module tag_tracker_tb;

    localparam int RAND_CMDS  = 300;
    localparam int MAX_CYCLES = (RAND_CMDS + 60) * 15 + 600;  // 15 cycles per checked command
    localparam int CNT_MAX    = (1 << tag_pkg::CNT_W) - 1;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [tag_pkg::APB_AW-1:0]  paddr;
    logic [tag_pkg::APB_DW-1:0]  pwdata;
    logic [tag_pkg::APB_DW-1:0]  prdata;
    logic                        pready;
    logic                        pslverr;

    // Reference model state
    logic [tag_pkg::TAG_W-1:0]     m_tag [tag_pkg::TAG_DEPTH];
    logic [tag_pkg::TAG_DEPTH-1:0] m_vld;
    int                            m_occ;
    int                            m_alloc;
    int                            m_reject;
    int                            m_miss;
    logic                          m_last_hit;

    int err_cnt;
    int cyc_cnt;
    int seed;

    always #2 clk = ~clk;   // 4 ns period

    tag_tracker_top i_dut (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_prdata  (prdata),
        .o_pready  (pready),
        .o_pslverr (pslverr)
    );

    bind cam_tag tag_tracker_sva #(.DEPTH(DEPTH)) i_cam_sva (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cmd_valid (i_cmd_valid),
        .i_res_valid (o_res_valid),
        .i_empty     (o_empty),
        .i_full      (o_full),
        .i_occupancy (o_occupancy)
    );

    //////////////////////////////////////////////////
    // Reference model

    function automatic int bump_saturating(input int val);
        return (val == CNT_MAX) ? val : val + 1;   // Counters stick at all ones
    endfunction

    // Applies one command to the model, returns the outcome
    function automatic logic model_step(input tag_pkg::tag_op_e op,
                                        input logic [tag_pkg::TAG_W-1:0] tag);
        int   idx;
        logic ok;
        idx = -1;
        ok  = 1'b0;
        case (op)
            tag_pkg::OP_ALLOC: begin
                for (int i = 0; i < tag_pkg::TAG_DEPTH; i++) begin
                    if (!m_vld[i] && idx < 0) idx = i;   // Lowest free slot
                end
                ok = (idx >= 0);
                if (ok) begin
                    m_vld[idx] = 1'b1;
                    m_tag[idx] = tag;
                    m_occ++;
                    m_alloc = bump_saturating(m_alloc);
                end else begin
                    m_reject = bump_saturating(m_reject);   // Array full
                end
            end
            tag_pkg::OP_RETIRE: begin
                for (int i = 0; i < tag_pkg::TAG_DEPTH; i++) begin
                    if (m_vld[i] && m_tag[i] == tag) idx = i;   // Highest match wins
                end
                ok = (idx >= 0);
                if (ok) begin
                    m_vld[idx] = 1'b0;
                    m_occ--;
                end else begin
                    m_miss = bump_saturating(m_miss);
                end
            end
            tag_pkg::OP_LOOKUP: begin
                for (int i = 0; i < tag_pkg::TAG_DEPTH; i++) begin
                    if (m_vld[i] && m_tag[i] == tag) ok = 1'b1;
                end
                m_last_hit = ok;
            end
            default: begin
                ok = 1'b0;   // NOP leaves the model alone
            end
        endcase
        return ok;
    endfunction

    //////////////////////////////////////////////////
    // APB access and compare tasks

    // Called 1 ns after a rising edge, returns 1 ns after the access edge
    task automatic apb_write(input logic [tag_pkg::APB_AW-1:0] addr,
                             input logic [tag_pkg::APB_DW-1:0] data, output logic err);
        psel    = 1'b1;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1 penable = 1'b1;
        #1 err = pslverr;   // Stable mid access phase
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [tag_pkg::APB_AW-1:0] addr,
                            output logic [tag_pkg::APB_DW-1:0] data, output logic err);
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1 penable = 1'b1;
        #1 data = prdata;
        err = pslverr;
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp, act);
            err_cnt++;
        end
    endtask

    // Reads every status register and compares with the model
    task automatic verify_registers(input string name);
        logic [31:0] data;
        logic        err;
        logic        err_any;
        apb_read(tag_pkg::REG_STATUS, data, err);
        err_any = err;
        compare_value({name, " status"},
                      {29'd0, m_last_hit, m_occ == tag_pkg::TAG_DEPTH, m_occ == 0}, data);
        apb_read(tag_pkg::REG_ALLOC_CNT, data, err);
        err_any |= err;
        compare_value({name, " alloc_cnt"}, m_alloc, data);
        apb_read(tag_pkg::REG_REJECT_CNT, data, err);
        err_any |= err;
        compare_value({name, " reject_cnt"}, m_reject, data);
        apb_read(tag_pkg::REG_MISS_CNT, data, err);
        err_any |= err;
        compare_value({name, " miss_cnt"}, m_miss, data);
        apb_read(tag_pkg::REG_OCCUPANCY, data, err);
        err_any |= err;
        compare_value({name, " occupancy"}, m_occ, data);
        compare_value({name, " read pslverr"}, 0, err_any);   // Legal reads never error
    endtask

    // Command write, 3 idle cycles for the pipe, then a full register check
    task automatic issue_cmd(input string name, input tag_pkg::tag_op_e op,
                             input logic [tag_pkg::TAG_W-1:0] tag);
        logic err;
        apb_write(tag_pkg::REG_CMD, {16'h0, tag, 6'h0, op}, err);
        compare_value({name, " cmd pslverr"}, 0, err);
        void'(model_step(op, tag));
        repeat (3) @(posedge clk);
        #1;
        verify_registers(name);
    endtask

    //////////////////////////////////////////////////
    // Stimulus and checking

    initial begin
        logic [31:0]               data;
        logic                      err;
        logic [tag_pkg::TAG_W-1:0] tag;
        tag_pkg::tag_op_e          op;
        int                        pick;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        rst_n      = 1'b0;
        m_vld      = '0;
        m_occ      = 0;
        m_alloc    = 0;
        m_reject   = 0;
        m_miss     = 0;
        m_last_hit = 1'b0;
        err_cnt    = 0;
        seed       = 94;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        compare_value("reset pready", 1, pready);
        verify_registers("reset");

        // Fill all slots, then one alloc too many
        for (int i = 0; i < tag_pkg::TAG_DEPTH; i++) begin
            issue_cmd($sformatf("fill %0d", i), tag_pkg::OP_ALLOC, 8'h40 + i[7:0]);
        end
        issue_cmd("fill overflow", tag_pkg::OP_ALLOC, 8'hEE);

        issue_cmd("lookup present", tag_pkg::OP_LOOKUP, 8'h43);
        issue_cmd("lookup absent", tag_pkg::OP_LOOKUP, 8'h99);

        issue_cmd("retire present", tag_pkg::OP_RETIRE, 8'h45);
        issue_cmd("retire absent", tag_pkg::OP_RETIRE, 8'hAA);
        for (int i = 0; i < tag_pkg::TAG_DEPTH; i++) begin
            if (i != 5) issue_cmd($sformatf("drain %0d", i), tag_pkg::OP_RETIRE, 8'h40 + i[7:0]);
        end

        // Small tag pool so duplicates, misses and full array all occur
        for (int n = 0; n < RAND_CMDS; n++) begin
            tag  = 8'($unsigned($random(seed)) % 24);
            pick = $unsigned($random(seed)) % 8;
            case (pick)
                0, 1, 2: op = tag_pkg::OP_ALLOC;
                3, 4:    op = tag_pkg::OP_RETIRE;
                5, 6:    op = tag_pkg::OP_LOOKUP;
                default: op = tag_pkg::OP_NOP;
            endcase
            issue_cmd($sformatf("random %0d", n), op, tag);
        end

        // Illegal write carries an alloc, so a leaked command would move a counter
        apb_write(tag_pkg::REG_STATUS, {16'h0, 8'h05, 6'h0, tag_pkg::OP_ALLOC}, err);
        compare_value("bad write pslverr", 1, err);
        apb_read(8'h20, data, err);
        compare_value("unmapped read pslverr", 1, err);
        compare_value("unmapped read data", 0, data);
        repeat (3) @(posedge clk);
        #1;
        verify_registers("bad access");

        $display("Run complete, errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        cyc_cnt = 0;
        while (cyc_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cyc_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule : tag_tracker_tb

// ==== build.f ====
rtl/tag_pkg.sv
rtl/apb_tag_if.sv
rtl/cam_tag.sv
rtl/tag_result_stage.sv
rtl/tag_tracker_top.sv
dv/tag_tracker_sva.sv
dv/tag_tracker_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the tag tracker testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module tag_tracker_tb -o Vtag_tracker_tb

sim_out="$(./obj_dir/Vtag_tracker_tb 2>&1 || true)"
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
echo "run_sim: testbench did not report a pass"
exit 1
